// File: hw/cache_pkg.sv
package cache_pkg;

   // Front-end bus geometry
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int NBYTES     = DATA_W / 8;
   localparam int BYTE_OFF_W = 2;   // Byte select bits dropped from word addresses

   // Front-end request, a zero strobe marks a read
   typedef struct packed {
      logic [ADDR_W-BYTE_OFF_W-1:0] addr;   // Word address
      logic [DATA_W-1:0]            wdata;
      logic [NBYTES-1:0]            wstrb;
   } fe_req_t;

   // Pending write-through entry, also the back-end write payload
   typedef struct packed {
      logic [ADDR_W-BYTE_OFF_W-1:0] addr;
      logic [DATA_W-1:0]            wdata;
      logic [NBYTES-1:0]            wstrb;
   } wtb_entry_t;

   // One pulse per completed access
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } stat_pulse_t;

endpackage

// File: hw/cache_tag_store.sv
`timescale 1ns/100ps

module cache_tag_store #(
   parameter int LINE_OFF_W = 4,
   parameter int WORD_OFF_W = 2
) (
   input  logic                                           clk,
   input  logic                                           rst,
   input  logic [cache_pkg::ADDR_W-cache_pkg::BYTE_OFF_W-1:0] lookup_addr,
   input  logic                                           refill_done,
   input  logic                                           invalidate,
   output logic                                           hit
);
   import cache_pkg::*;

   localparam int WADDR_W = ADDR_W - BYTE_OFF_W;
   localparam int TAG_W   = WADDR_W - LINE_OFF_W - WORD_OFF_W;
   localparam int NLINES  = 2 ** LINE_OFF_W;

   logic [TAG_W-1:0]      tag_mem [NLINES];
   logic [NLINES-1:0]     line_valid;
   logic [LINE_OFF_W-1:0] idx_q;
   logic [TAG_W-1:0]      tag_q;

   // Synchronous lookup, index and tag held for the compare
   always_ff @(posedge clk) begin
      idx_q <= lookup_addr[WORD_OFF_W +: LINE_OFF_W];
      tag_q <= lookup_addr[WADDR_W-1 -: TAG_W];
      if (refill_done) begin
         tag_mem[idx_q] <= tag_q;   // Line now belongs to the refilled tag
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         line_valid <= '0;
      end else if (invalidate) begin
         line_valid <= '0;          // Flush every line at once
      end else if (refill_done) begin
         line_valid[idx_q] <= 1'b1;
      end
   end

   // Tag written on the same edge is visible here in the next cycle
   assign hit = line_valid[idx_q] && (tag_mem[idx_q] == tag_q);

endmodule

// File: hw/cache_data_store.sv
`timescale 1ns/100ps

module cache_data_store #(
   parameter int LINE_OFF_W = 4,
   parameter int WORD_OFF_W = 2
) (
   input  logic                               clk,
   input  logic [LINE_OFF_W+WORD_OFF_W-1:0]   lookup_addr,
   input  logic                               word_write,
   input  logic [cache_pkg::NBYTES-1:0]       word_wstrb,
   input  logic [cache_pkg::DATA_W-1:0]       word_wdata,
   input  logic                               refill_beat,
   input  logic [WORD_OFF_W-1:0]              refill_word,
   input  logic [cache_pkg::DATA_W-1:0]       refill_data,
   output logic [cache_pkg::DATA_W-1:0]       rdata
);
   import cache_pkg::*;

   localparam int IDX_W  = LINE_OFF_W + WORD_OFF_W;
   localparam int NWORDS = 2 ** IDX_W;

   logic [DATA_W-1:0] mem [NWORDS];
   logic [IDX_W-1:0]  addr_q;     // Word currently under lookup
   logic [IDX_W-1:0]  fill_idx;
   logic [DATA_W-1:0] rd_word;

   // Refill beats land in the line of the registered address
   assign fill_idx = {addr_q[IDX_W-1 -: LINE_OFF_W], refill_word};

   // Read value including any write to the same word this cycle
   always_comb begin
      rd_word = mem[lookup_addr];
      if (refill_beat && (fill_idx == lookup_addr)) begin
         rd_word = refill_data;
      end
      if (word_write && (addr_q == lookup_addr)) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (word_wstrb[b]) rd_word[8*b +: 8] = word_wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (refill_beat) mem[fill_idx] <= refill_data;
      if (word_write) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (word_wstrb[b]) mem[addr_q][8*b +: 8] <= word_wdata[8*b +: 8];   // Strobed bytes only
         end
      end
      addr_q <= lookup_addr;
      rdata  <= rd_word;
   end

endmodule

// File: hw/write_through_buffer.sv
`timescale 1ns/100ps

module write_through_buffer #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  push,
   input  cache_pkg::wtb_entry_t push_entry,
   input  logic                  pop,
   output cache_pkg::wtb_entry_t head,
   output logic                  full,
   output logic                  empty
);
   import cache_pkg::*;

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   wtb_entry_t               mem [DEPTH];
   logic [WTBUF_DEPTH_W:0]   wr_ptr;   // Top bit is the wrap flag
   logic [WTBUF_DEPTH_W:0]   rd_ptr;
   logic                     do_push;
   logic                     do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= push_entry;
   end

   // Same slot, different lap means full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[WTBUF_DEPTH_W] != rd_ptr[WTBUF_DEPTH_W]) &&
                  (wr_ptr[WTBUF_DEPTH_W-1:0] == rd_ptr[WTBUF_DEPTH_W-1:0]);

   assign head = mem[rd_ptr[WTBUF_DEPTH_W-1:0]];

endmodule

// File: hw/cache_memory_core.sv
`timescale 1ns/100ps

module cache_memory_core #(
   parameter int LINE_OFF_W    = 4,
   parameter int WORD_OFF_W    = 2,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        valid,
   input  cache_pkg::fe_req_t          req,
   output logic                        ready,
   output logic [cache_pkg::DATA_W-1:0] rdata,
   output logic                        write_valid,
   output cache_pkg::wtb_entry_t       write_entry,
   input  logic                        write_ready,
   output logic                        replace_valid,
   output logic [cache_pkg::ADDR_W-cache_pkg::BYTE_OFF_W-WORD_OFF_W-1:0] replace_addr,
   input  logic                        replace_ready,
   input  logic                        read_valid,
   input  logic [WORD_OFF_W-1:0]       read_addr,
   input  logic [cache_pkg::DATA_W-1:0] read_rdata,
   input  logic                        invalidate,
   output cache_pkg::stat_pulse_t      stats,
   output logic                        wtb_full,
   output logic                        wtb_empty
);
   import cache_pkg::*;

   localparam int WADDR_W = ADDR_W - BYTE_OFF_W;

   typedef enum logic [1:0] {S_LOOKUP, S_DRAIN, S_REQ, S_REFILL} state_t;

   state_t                 state;
   logic                   stage_valid;
   fe_req_t                stage_req;
   logic                   missed;     // Current read needed a refill
   logic                   inv_pend;
   logic [WORD_OFF_W-1:0]  beat_cnt;
   logic [WADDR_W-1:0]     lookup_addr;
   logic                   hit, is_write, in_lookup;
   logic                   refill_beat, last_beat, inv_apply, push;
   wtb_entry_t             push_entry;

   assign lookup_addr = stage_valid ? stage_req.addr : req.addr;
   assign is_write    = |stage_req.wstrb;
   assign in_lookup   = stage_valid && (state == S_LOOKUP);
   assign ready       = in_lookup && (is_write ? !wtb_full : hit);
   assign push        = ready && is_write;   // Hit or miss, every write goes out

   assign refill_beat   = (state == S_REFILL) && read_valid;
   assign last_beat     = refill_beat && (beat_cnt == '1);
   assign replace_valid = (state == S_REQ);
   assign replace_addr  = stage_req.addr[WADDR_W-1:WORD_OFF_W];
   assign write_valid   = !wtb_empty;
   assign inv_apply     = (invalidate || inv_pend) && (state == S_LOOKUP);

   assign push_entry.addr  = stage_req.addr;
   assign push_entry.wdata = stage_req.wdata;
   assign push_entry.wstrb = stage_req.wstrb;

   assign stats.read_hit   = ready && !is_write && !missed;
   assign stats.read_miss  = ready && !is_write && missed;
   assign stats.write_hit  = ready && is_write && hit;
   assign stats.write_miss = ready && is_write && !hit;

   always_ff @(posedge clk) begin
      if (!stage_valid) stage_req <= req;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= S_LOOKUP;
         stage_valid <= 1'b0;
         missed      <= 1'b0;
         inv_pend    <= 1'b0;
         beat_cnt    <= '0;
      end else begin
         if (!stage_valid && valid) stage_valid <= 1'b1;
         if (state != S_LOOKUP && invalidate) inv_pend <= 1'b1;   // Held until refill ends
         else if (state == S_LOOKUP) inv_pend <= 1'b0;
         case (state)
            S_LOOKUP: begin
               if (ready) begin
                  stage_valid <= 1'b0;
                  missed      <= 1'b0;
               end else if (stage_valid && !is_write && !hit) begin
                  state  <= S_DRAIN;
                  missed <= 1'b1;
               end
            end
            S_DRAIN: if (wtb_empty) state <= S_REQ;   // Memory must see older writes first
            S_REQ: begin
               if (replace_ready) begin
                  state    <= S_REFILL;
                  beat_cnt <= '0;
               end
            end
            default: begin
               if (refill_beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat) state <= S_LOOKUP;   // Relook now hits
               end
            end
         endcase
      end
   end

   cache_tag_store #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) u_tag_store (
      .clk         (clk),
      .rst         (rst),
      .lookup_addr (lookup_addr),
      .refill_done (last_beat),
      .invalidate  (inv_apply),
      .hit         (hit)
   );

   cache_data_store #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) u_data_store (
      .clk         (clk),
      .lookup_addr (lookup_addr[LINE_OFF_W+WORD_OFF_W-1:0]),
      .word_write  (push && hit),
      .word_wstrb  (stage_req.wstrb),
      .word_wdata  (stage_req.wdata),
      .refill_beat (refill_beat),
      .refill_word (read_addr),
      .refill_data (read_rdata),
      .rdata       (rdata)
   );

   write_through_buffer #(
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) u_wtb (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_entry (push_entry),
      .pop        (write_valid && write_ready),
      .head       (write_entry),
      .full       (wtb_full),
      .empty      (wtb_empty)
   );

endmodule

// File: hw/cache_status_regs.sv
`timescale 1ns/100ps

module cache_status_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  cache_pkg::stat_pulse_t stats,
   input  logic                   wtb_full,
   input  logic                   wtb_empty,
   output logic [15:0]            read_hit_count,
   output logic [15:0]            read_miss_count,
   output logic [15:0]            write_hit_count,
   output logic [15:0]            write_miss_count,
   output logic [1:0]             wtb_status
);

   localparam int CNT_W = 16;

   logic [3:0]       pulse;
   logic [CNT_W-1:0] cnt [4];

   assign pulse = {stats.write_miss, stats.write_hit, stats.read_miss, stats.read_hit};

   // Same saturating counter for every event class
   for (genvar i = 0; i < 4; i++) begin : g_cnt
      always_ff @(posedge clk) begin
         if (rst) begin
            cnt[i] <= '0;
         end else if (pulse[i] && (cnt[i] != '1)) begin
            cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) wtb_status <= 2'b00;
      else wtb_status <= {wtb_full, wtb_empty};
   end

   assign read_hit_count   = cnt[0];
   assign read_miss_count  = cnt[1];
   assign write_hit_count  = cnt[2];
   assign write_miss_count = cnt[3];

endmodule

// File: hw/cache_memory.sv
`timescale 1ns/100ps

module cache_memory #(
   parameter int LINE_OFF_W    = 4,
   parameter int WORD_OFF_W    = 2,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        valid,
   input  cache_pkg::fe_req_t          req,
   output logic                        ready,
   output logic [cache_pkg::DATA_W-1:0] rdata,
   output logic                        write_valid,
   output cache_pkg::wtb_entry_t       write_entry,
   input  logic                        write_ready,
   output logic                        replace_valid,
   output logic [cache_pkg::ADDR_W-cache_pkg::BYTE_OFF_W-WORD_OFF_W-1:0] replace_addr,
   input  logic                        replace_ready,
   input  logic                        read_valid,
   input  logic [WORD_OFF_W-1:0]       read_addr,
   input  logic [cache_pkg::DATA_W-1:0] read_rdata,
   input  logic                        invalidate,
   output logic [15:0]                 read_hit_count,
   output logic [15:0]                 read_miss_count,
   output logic [15:0]                 write_hit_count,
   output logic [15:0]                 write_miss_count,
   output logic [1:0]                  wtb_status
);
   import cache_pkg::*;

   stat_pulse_t stats;
   logic        wtb_full;
   logic        wtb_empty;

   cache_memory_core #(
      .LINE_OFF_W    (LINE_OFF_W),
      .WORD_OFF_W    (WORD_OFF_W),
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) u_core (
      .clk           (clk),
      .rst           (rst),
      .valid         (valid),
      .req           (req),
      .ready         (ready),
      .rdata         (rdata),
      .write_valid   (write_valid),
      .write_entry   (write_entry),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .invalidate    (invalidate),
      .stats         (stats),
      .wtb_full      (wtb_full),
      .wtb_empty     (wtb_empty)
   );

   cache_status_regs u_status (
      .clk              (clk),
      .rst              (rst),
      .stats            (stats),
      .wtb_full         (wtb_full),
      .wtb_empty        (wtb_empty),
      .read_hit_count   (read_hit_count),
      .read_miss_count  (read_miss_count),
      .write_hit_count  (write_hit_count),
      .write_miss_count (write_miss_count),
      .wtb_status       (wtb_status)
   );

endmodule

// File: verif/cache_checker.sv
`timescale 1ns/100ps

module cache_checker #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         done,
   input  logic                         exp_hit,
   input  logic                         valid,
   input  cache_pkg::fe_req_t           req,
   input  logic                         ready,
   input  logic [cache_pkg::DATA_W-1:0] rdata,
   input  logic                         write_valid,
   input  logic                         write_ready,
   input  cache_pkg::wtb_entry_t        write_entry,
   input  logic [15:0]                  read_hit_count,
   input  logic [15:0]                  read_miss_count,
   input  logic [15:0]                  write_hit_count,
   input  logic [15:0]                  write_miss_count,
   input  logic [1:0]                   wtb_status,
   output int                           error_total
);
   import cache_pkg::*;

   logic [DATA_W-1:0] shadow [256];   // Expected backing memory contents
   wtb_entry_t        exp_writes [$];
   int                exp_cnt [4];    // Read hit, read miss, write hit, write miss
   int                data_errs = 0;
   int                class_errs = 0;
   int                write_errs = 0;
   int                other_errs = 0;
   int                wait_cnt = 0;
   logic              cnt_due = 1'b0;
   logic              seen_full = 1'b0;
   logic              reported = 1'b0;
   logic [1:0]        flags_next = 2'b01;    // Full and empty after the latest edge
   logic [1:0]        flags_shown = 2'b00;   // What the status register holds now

   assign error_total = data_errs + class_errs + write_errs + other_errs;

   // Power-up contents of the memory behind the cache
   function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] a);
      return {a ^ 8'h3c, ~a, a, a + 8'h5a};
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) shadow[i] = fill_word(i[7:0]);
      for (int i = 0; i < 4; i++) exp_cnt[i] = 0;
   end

   task automatic compare_counts();
      if (read_hit_count != exp_cnt[0] || read_miss_count != exp_cnt[1] ||
          write_hit_count != exp_cnt[2] || write_miss_count != exp_cnt[3]) begin
         $display("mismatch at %0t: counters %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
                  $time, read_hit_count, read_miss_count, write_hit_count,
                  write_miss_count, exp_cnt[0], exp_cnt[1], exp_cnt[2], exp_cnt[3]);
         class_errs++;
      end
   endtask

   always @(posedge clk) begin
      wtb_entry_t entry;
      int         cls;
      if (!rst) begin
         if (cnt_due) compare_counts();   // Counters settle one edge after the access
         cnt_due = 1'b0;
         if (wtb_status !== flags_shown) begin
            $display("mismatch at %0t: buffer status %b, expected %b",
                     $time, wtb_status, flags_shown);
            other_errs++;
         end
         flags_shown = flags_next;   // Status register lags the buffer by one edge
         if (wtb_status[1]) seen_full = 1'b1;
         if (valid && ready) begin
            if (req.wstrb != '0) begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (req.wstrb[b]) shadow[req.addr[7:0]][8*b +: 8] = req.wdata[8*b +: 8];
               end
               entry.addr  = req.addr;
               entry.wdata = req.wdata;
               entry.wstrb = req.wstrb;
               exp_writes.push_back(entry);
               cls = exp_hit ? 2 : 3;
            end else begin
               if (rdata !== shadow[req.addr[7:0]]) begin
                  $display("mismatch at %0t: read of word 0x%0h gave 0x%08h, expected 0x%08h",
                           $time, req.addr, rdata, shadow[req.addr[7:0]]);
                  data_errs++;
               end
               if (exp_hit && wait_cnt != 1) begin
                  $display("read hit at %0t took %0d cycles instead of one", $time, wait_cnt);
                  other_errs++;
               end
               cls = exp_hit ? 0 : 1;
            end
            exp_cnt[cls]++;
            cnt_due  = 1'b1;
            wait_cnt = 0;
         end else if (valid) begin
            wait_cnt++;
         end
         if (write_valid && write_ready) begin
            if (exp_writes.size() == 0) begin
               $display("back-end write at %0t with no write pending", $time);
               other_errs++;
            end else begin
               entry = exp_writes.pop_front();
               if (write_entry !== entry) begin
                  $display("mismatch at %0t: back-end write %0h/%08h/%h, expected %0h/%08h/%h",
                           $time, write_entry.addr, write_entry.wdata, write_entry.wstrb,
                           entry.addr, entry.wdata, entry.wstrb);
                  write_errs++;
               end
            end
         end
         flags_next = {exp_writes.size() == 2 ** WTBUF_DEPTH_W, exp_writes.size() == 0};
         if (done && !reported) begin
            compare_counts();
            if (exp_writes.size() != 0) begin
               $display("%0d writes never reached the back end", exp_writes.size());
               other_errs++;
            end
            if (!seen_full) begin
               $display("write buffer never reported full");
               other_errs++;
            end
            $display("error counts: data %0d, class %0d, write channel %0d, other %0d",
                     data_errs, class_errs, write_errs, other_errs);
            reported = 1'b1;
         end
      end
   end

endmodule

// File: verif/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
   import cache_pkg::*;

   localparam int LINE_OFF_W    = 4;
   localparam int WORD_OFF_W    = 2;
   localparam int WTBUF_DEPTH_W = 2;
   localparam int MAX_ROWS      = 40;
   localparam int HOLD_CYCLES   = 20;   // Long enough to fill the write buffer

   localparam logic [1:0] OP_RD   = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_INV  = 2'd2;
   localparam logic [1:0] OP_HOLD = 2'd3;   // Stall the back-end write channel
   localparam logic       HIT     = 1'b1;
   localparam logic       MISS    = 1'b0;

   localparam int RF_IDLE  = 0;
   localparam int RF_GRANT = 1;
   localparam int RF_BEATS = 2;

   typedef struct packed {
      logic [1:0]        op;
      logic [ADDR_W-1:0] addr;   // Byte address
      logic [DATA_W-1:0] data;
      logic [NBYTES-1:0] strb;
      logic              hit;    // Expected class
   } row_t;

   logic                                    clk = 1'b0;
   logic                                    rst;
   logic                                    valid;
   fe_req_t                                 req;
   logic                                    ready;
   logic [DATA_W-1:0]                       rdata;
   logic                                    write_valid;
   wtb_entry_t                              write_entry;
   logic                                    write_ready = 1'b0;
   logic                                    replace_valid;
   logic [ADDR_W-BYTE_OFF_W-WORD_OFF_W-1:0] replace_addr;
   logic                                    replace_ready = 1'b0;
   logic                                    read_valid = 1'b0;
   logic [WORD_OFF_W-1:0]                   read_addr = '0;
   logic [DATA_W-1:0]                       read_rdata = '0;
   logic                                    invalidate;
   logic [15:0]                             read_hit_count;
   logic [15:0]                             read_miss_count;
   logic [15:0]                             write_hit_count;
   logic [15:0]                             write_miss_count;
   logic [1:0]                              wtb_status;
   logic                                    exp_hit;
   logic                                    done;
   int                                      error_total;

   row_t              rows [MAX_ROWS];
   int                n_rows = 0;
   int                cycles = 0;
   int                limit = 0;
   int                seed = 77375;
   int                hold_cnt = 0;
   logic [DATA_W-1:0] bmem [256];   // Backing memory, word addressed
   int                rf_state = RF_IDLE;
   int                rf_base = 0;
   int                rf_first = 0;
   int                rf_beat = 0;
   int                gap_cnt = 0;

   always #10 clk = ~clk;

   function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] a);
      return {a ^ 8'h3c, ~a, a, a + 8'h5a};
   endfunction

   function automatic int rand_below(input int n);
      return {$random(seed)} % n;
   endfunction

   // Back-end memory model, random write back-pressure and refill gaps
   always @(negedge clk) begin
      int w;
      if (hold_cnt > 0) begin
         write_ready = 1'b0;
         hold_cnt    = hold_cnt - 1;
      end else begin
         write_ready = (rand_below(2) == 1);
      end
      if (write_valid && write_ready) begin   // Pops on the coming edge
         for (int b = 0; b < NBYTES; b++) begin
            if (write_entry.wstrb[b])
               bmem[write_entry.addr[7:0]][8*b +: 8] = write_entry.wdata[8*b +: 8];
         end
      end
      replace_ready = 1'b0;
      read_valid    = 1'b0;
      if (gap_cnt > 0) begin
         gap_cnt = gap_cnt - 1;
      end else if (rf_state == RF_GRANT) begin
         replace_ready = 1'b1;
         rf_base       = int'(replace_addr) << WORD_OFF_W;
         rf_first      = rand_below(2 ** WORD_OFF_W);   // Beats start anywhere in the line
         rf_beat       = 0;
         rf_state      = RF_BEATS;
         gap_cnt       = rand_below(4);
      end else if (rf_state == RF_BEATS) begin
         w          = (rf_first + rf_beat) % (2 ** WORD_OFF_W);
         read_valid = 1'b1;
         read_addr  = w[WORD_OFF_W-1:0];
         read_rdata = bmem[rf_base + w];
         rf_beat    = rf_beat + 1;
         gap_cnt    = rand_below(4);
         if (rf_beat == 2 ** WORD_OFF_W) rf_state = RF_IDLE;
      end else if (replace_valid) begin
         rf_state = RF_GRANT;
         gap_cnt  = rand_below(4);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("run timed out after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic add_row(input logic [1:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [NBYTES-1:0] strb,
                          input logic hit);
      rows[n_rows] = {op, addr, data, strb, hit};
      n_rows++;
   endtask

   task automatic load_table();
      add_row(OP_RD, 32'h000, 32'h0, 4'h0, MISS);            // Cold line
      add_row(OP_RD, 32'h000, 32'h0, 4'h0, HIT);
      add_row(OP_RD, 32'h004, 32'h0, 4'h0, HIT);
      add_row(OP_WR, 32'h008, 32'hdead_beef, 4'b0011, HIT);  // Partial write hit
      add_row(OP_RD, 32'h008, 32'h0, 4'h0, HIT);
      add_row(OP_WR, 32'h050, 32'h1122_3344, 4'b1111, MISS);
      add_row(OP_RD, 32'h050, 32'h0, 4'h0, MISS);            // Buffer drains first
      add_row(OP_RD, 32'h054, 32'h0, 4'h0, HIT);
      add_row(OP_RD, 32'h020, 32'h0, 4'h0, MISS);            // Index 2, tag 0
      add_row(OP_RD, 32'h120, 32'h0, 4'h0, MISS);            // Index 2, tag 1
      add_row(OP_RD, 32'h020, 32'h0, 4'h0, MISS);
      add_row(OP_RD, 32'h02c, 32'h0, 4'h0, HIT);
      add_row(OP_INV, 32'h0, 32'h0, 4'h0, MISS);
      add_row(OP_RD, 32'h020, 32'h0, 4'h0, MISS);
      add_row(OP_RD, 32'h000, 32'h0, 4'h0, MISS);
      add_row(OP_HOLD, 32'h0, 32'h0, 4'h0, MISS);
      add_row(OP_WR, 32'h000, 32'h0123_4567, 4'b1111, HIT);
      add_row(OP_WR, 32'h004, 32'h89ab_cdef, 4'b0100, HIT);
      add_row(OP_WR, 32'h00c, 32'h5566_7788, 4'b1000, HIT);
      add_row(OP_WR, 32'h300, 32'ha5a5_5a5a, 4'b1111, MISS);
      add_row(OP_WR, 32'h304, 32'h0f0f_f0f0, 4'b0110, MISS); // Waits for a free slot
      add_row(OP_RD, 32'h000, 32'h0, 4'h0, HIT);
      add_row(OP_RD, 32'h004, 32'h0, 4'h0, HIT);
      add_row(OP_RD, 32'h00c, 32'h0, 4'h0, HIT);
      add_row(OP_RD, 32'h300, 32'h0, 4'h0, MISS);
      add_row(OP_RD, 32'h304, 32'h0, 4'h0, HIT);
   endtask

   task automatic apply_row(input row_t row);
      case (row.op)
         OP_INV: begin
            invalidate = 1'b1;
            @(negedge clk);
            invalidate = 1'b0;
         end
         OP_HOLD: begin
            @(posedge clk);
            hold_cnt = HOLD_CYCLES;
            @(negedge clk);
         end
         default: begin
            req.addr  = row.addr[ADDR_W-1:BYTE_OFF_W];
            req.wdata = row.data;
            req.wstrb = (row.op == OP_WR) ? row.strb : '0;
            exp_hit   = row.hit;
            valid     = 1'b1;
            @(negedge clk);
            while (!ready) @(negedge clk);
            @(negedge clk);   // Accepting edge has passed
            valid = 1'b0;
         end
      endcase
   endtask

   initial begin
      rst        = 1'b1;
      valid      = 1'b0;
      req        = '0;
      invalidate = 1'b0;
      exp_hit    = 1'b0;
      done       = 1'b0;
      for (int i = 0; i < 256; i++) bmem[i] = fill_word(i[7:0]);
      load_table();
      limit = 4 + n_rows * (2 ** WORD_OFF_W + 40);
      repeat (4) @(negedge clk);
      rst = 1'b0;
      for (int r = 0; r < n_rows; r++) apply_row(rows[r]);
      while (write_valid) @(negedge clk);
      done = 1'b1;
      repeat (2) @(negedge clk);
      if (error_total == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   cache_memory #(
      .LINE_OFF_W    (LINE_OFF_W),
      .WORD_OFF_W    (WORD_OFF_W),
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) u_cache_memory (
      .clk              (clk),
      .rst              (rst),
      .valid            (valid),
      .req              (req),
      .ready            (ready),
      .rdata            (rdata),
      .write_valid      (write_valid),
      .write_entry      (write_entry),
      .write_ready      (write_ready),
      .replace_valid    (replace_valid),
      .replace_addr     (replace_addr),
      .replace_ready    (replace_ready),
      .read_valid       (read_valid),
      .read_addr        (read_addr),
      .read_rdata       (read_rdata),
      .invalidate       (invalidate),
      .read_hit_count   (read_hit_count),
      .read_miss_count  (read_miss_count),
      .write_hit_count  (write_hit_count),
      .write_miss_count (write_miss_count),
      .wtb_status       (wtb_status)
   );

   cache_checker #(
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) u_cache_checker (
      .clk              (clk),
      .rst              (rst),
      .done             (done),
      .exp_hit          (exp_hit),
      .valid            (valid),
      .req              (req),
      .ready            (ready),
      .rdata            (rdata),
      .write_valid      (write_valid),
      .write_ready      (write_ready),
      .write_entry      (write_entry),
      .read_hit_count   (read_hit_count),
      .read_miss_count  (read_miss_count),
      .write_hit_count  (write_hit_count),
      .write_miss_count (write_miss_count),
      .wtb_status       (wtb_status),
      .error_total      (error_total)
   );

endmodule

// File: compile.f
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/write_through_buffer.sv
hw/cache_memory_core.sv
hw/cache_status_regs.sv
hw/cache_memory.sv
verif/cache_checker.sv
verif/cache_tb.sv

// File: Bender.yml
package:
  name: cache_memory

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/cache_tag_store.sv
      - hw/cache_data_store.sv
      - hw/write_through_buffer.sv
      - hw/cache_memory_core.sv
      - hw/cache_status_regs.sv
      - hw/cache_memory.sv
  - target: test
    files:
      - verif/cache_checker.sv
      - verif/cache_tb.sv
